//--- source/host_event_pkg.sv
// Shared constants and types of the event monitor
// Event indices, register map, filler word and bus structs

package host_event_pkg;

  // Four cache events plus the cluster DMA event
  localparam int unsigned NUM_EVT = 5;

  localparam int unsigned CFG_AW = 8;
  localparam int unsigned CFG_DW = 32;

  // Register map, byte offsets
  localparam logic [CFG_AW-1:0] CTRL_OFFS     = 8'h00;
  localparam logic [CFG_AW-1:0] STATUS_OFFS   = 8'h04;
  localparam logic [CFG_AW-1:0] MASK_OFFS     = 8'h08;
  localparam logic [CFG_AW-1:0] CNT_BASE_OFFS = 8'h10;

  // Returned for any read outside the map
  localparam logic [CFG_DW-1:0] UNMAPPED_RDATA = 32'hdeadf000;

  typedef struct packed {
    logic [CFG_AW-1:0] addr;
    logic [CFG_DW-1:0] data;
  } cfg_wr_t;

  // Single-cycle pulses from the last-level cache
  typedef struct packed {
    logic read_hit;
    logic read_miss;
    logic write_hit;
    logic write_miss;
  } llc_events_t;

  // Decoded write strobes, valid for the acceptance cycle only
  typedef struct packed {
    logic               ctrl_we;
    logic               status_clr_we;
    logic               mask_we;
    logic [NUM_EVT-1:0] cnt_we;
    logic [CFG_DW-1:0]  data;
  } reg_wr_t;

endpackage

//--- source/cfg_reg_port.sv
// Register port with valid/ready write and read channels
// Write address decode into strobes, read mux and response holding

`timescale 1ns/1ps

module cfg_reg_port #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  // Write channel
  input  host_event_pkg::cfg_wr_t                                cfg_wr_i,
  input  logic                                                   wr_valid_i,
  output logic                                                   wr_ready_o,
  output logic                                                   b_valid_o,
  input  logic                                                   b_ready_i,
  // Read channel
  input  logic [host_event_pkg::CFG_AW-1:0]                      rd_addr_i,
  input  logic                                                   rd_valid_i,
  output logic                                                   rd_ready_o,
  output logic                                                   r_valid_o,
  input  logic                                                   r_ready_i,
  output logic [host_event_pkg::CFG_DW-1:0]                      r_data_o,
  // Towards the counter bank
  output host_event_pkg::reg_wr_t                                reg_wr_o,
  input  logic [host_event_pkg::NUM_EVT-1:0][CNT_WIDTH-1:0]      cnt_i,
  input  logic [host_event_pkg::NUM_EVT-1:0]                     ctrl_i,
  input  logic [host_event_pkg::NUM_EVT-1:0]                     status_i,
  input  logic [host_event_pkg::NUM_EVT-1:0]                     mask_i
);

  localparam int unsigned AW = host_event_pkg::CFG_AW;
  localparam int unsigned DW = host_event_pkg::CFG_DW;
  localparam int unsigned N  = host_event_pkg::NUM_EVT;

  logic          b_valid_q;
  logic          r_valid_q;
  logic [DW-1:0] r_data_q;
  logic [DW-1:0] rd_word;
  logic          wr_acc;
  logic          rd_acc;

  // Counter i sits one word above counter i-1
  function automatic logic [AW-1:0] cnt_addr(input int unsigned idx);
    cnt_addr = host_event_pkg::CNT_BASE_OFFS + AW'(4 * idx);
  endfunction

  // A new request is taken only when no response is waiting
  assign wr_ready_o = ~b_valid_q;
  assign rd_ready_o = ~r_valid_q;
  assign wr_acc     = wr_valid_i & wr_ready_o;
  assign rd_acc     = rd_valid_i & rd_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_acc) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_acc) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Write strobes for the bank, unknown addresses produce none
  always_comb begin
    reg_wr_o      = '0;
    reg_wr_o.data = cfg_wr_i.data;
    if (wr_acc) begin
      reg_wr_o.ctrl_we       = (cfg_wr_i.addr == host_event_pkg::CTRL_OFFS);
      reg_wr_o.status_clr_we = (cfg_wr_i.addr == host_event_pkg::STATUS_OFFS);
      reg_wr_o.mask_we       = (cfg_wr_i.addr == host_event_pkg::MASK_OFFS);
      for (int i = 0; i < N; i++) begin
        reg_wr_o.cnt_we[i] = (cfg_wr_i.addr == cnt_addr(i));
      end
    end
  end

  always_comb begin
    rd_word = host_event_pkg::UNMAPPED_RDATA;
    if (rd_addr_i == host_event_pkg::CTRL_OFFS) begin
      rd_word = DW'(ctrl_i);
    end else if (rd_addr_i == host_event_pkg::STATUS_OFFS) begin
      rd_word = DW'(status_i);
    end else if (rd_addr_i == host_event_pkg::MASK_OFFS) begin
      rd_word = DW'(mask_i);
    end
    for (int i = 0; i < N; i++) begin
      if (rd_addr_i == cnt_addr(i)) begin
        rd_word = DW'(cnt_i[i]);
      end
    end
  end

  // Read data is frozen at acceptance
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      r_data_q <= rd_word;
    end
  end

  assign b_valid_o = b_valid_q;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

//--- source/event_edge_rx.sv
// Toggle receiver for an event from another clock domain
// Two-flop synchronizer, acknowledge level and edge pulse

`timescale 1ns/1ps

module event_edge_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic pulse_o
);

  logic [1:0] sync_q;
  logic       prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b00;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], valid_i};
      prev_q <= sync_q[1];
    end
  end

  // Sender sees its own toggle echoed back
  assign ack_o = sync_q[1];

  // One cycle per level change
  assign pulse_o = sync_q[1] ^ prev_q;

endmodule

//--- source/perf_counter_bank.sv
// Event counters with enable, interrupt status and interrupt mask
// Wrap on overflow sets status; registered interrupt from masked status

`timescale 1ns/1ps

module perf_counter_bank #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  host_event_pkg::reg_wr_t                           reg_wr_i,
  input  logic [host_event_pkg::NUM_EVT-1:0]                evt_i,
  output logic [host_event_pkg::NUM_EVT-1:0][CNT_WIDTH-1:0] cnt_o,
  output logic [host_event_pkg::NUM_EVT-1:0]                ctrl_o,
  output logic [host_event_pkg::NUM_EVT-1:0]                status_o,
  output logic [host_event_pkg::NUM_EVT-1:0]                mask_o,
  output logic                                              irq_o
);

  localparam int unsigned N = host_event_pkg::NUM_EVT;

  logic [N-1:0]                ctrl_q;
  logic [N-1:0]                mask_q;
  logic [N-1:0]                status_q;
  logic [N-1:0]                status_d;
  logic [N-1:0]                inc;
  logic [N-1:0]                ovf;
  logic [N-1:0]                clr;
  logic [N-1:0][CNT_WIDTH-1:0] cnt_q;
  logic                        irq_q;

  // Only enabled events count
  assign inc = evt_i & ctrl_q;

  // A counter write in the same cycle suppresses the increment and its overflow
  always_comb begin
    for (int i = 0; i < N; i++) begin
      ovf[i] = inc[i] & ~reg_wr_i.cnt_we[i] & (&cnt_q[i]);
    end
  end

  // Write one to clear
  assign clr = reg_wr_i.status_clr_we ? reg_wr_i.data[N-1:0] : '0;

  // New overflow beats a same-cycle clear
  assign status_d = (status_q & ~clr) | ovf;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q   <= '0;
      mask_q   <= '0;
      status_q <= '0;
      irq_q    <= 1'b0;
    end else begin
      if (reg_wr_i.ctrl_we) begin
        ctrl_q <= reg_wr_i.data[N-1:0];
      end
      if (reg_wr_i.mask_we) begin
        mask_q <= reg_wr_i.data[N-1:0];
      end
      status_q <= status_d;
      irq_q    <= |(status_q & mask_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (reg_wr_i.cnt_we[i]) begin
          cnt_q[i] <= reg_wr_i.data[CNT_WIDTH-1:0];
        end else if (inc[i]) begin
          // Wraps to zero from all ones
          cnt_q[i] <= cnt_q[i] + CNT_WIDTH'(1);
        end
      end
    end
  end

  assign cnt_o    = cnt_q;
  assign ctrl_o   = ctrl_q;
  assign status_o = status_q;
  assign mask_o   = mask_q;
  assign irq_o    = irq_q;

endmodule

//--- source/host_event_monitor.sv
// Event monitor top level
// Register port, DMA event receiver and counter bank

`timescale 1ns/1ps

module host_event_monitor #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  host_event_pkg::cfg_wr_t           cfg_wr_i,
  input  logic                              wr_valid_i,
  output logic                              wr_ready_o,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  input  logic [host_event_pkg::CFG_AW-1:0] rd_addr_i,
  input  logic                              rd_valid_i,
  output logic                              rd_ready_o,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [host_event_pkg::CFG_DW-1:0] r_data_o,
  input  host_event_pkg::llc_events_t       llc_evt_i,
  input  logic                              dma_pe_evt_valid_i,
  output logic                              dma_pe_evt_ack_o,
  output logic                              irq_o
);

  localparam int unsigned N = host_event_pkg::NUM_EVT;

  host_event_pkg::reg_wr_t     reg_wr;
  logic [N-1:0][CNT_WIDTH-1:0] cnt;
  logic [N-1:0]                ctrl;
  logic [N-1:0]                status;
  logic [N-1:0]                mask;
  logic [N-1:0]                evt;
  logic                        dma_evt;

  // Index 0 is read hit, index 4 the DMA event
  assign evt = {dma_evt, llc_evt_i.write_miss, llc_evt_i.write_hit,
                llc_evt_i.read_miss, llc_evt_i.read_hit};

  cfg_reg_port #(
    .CNT_WIDTH  ( CNT_WIDTH  )
  ) i_cfg_reg_port (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .cfg_wr_i   ( cfg_wr_i   ),
    .wr_valid_i ( wr_valid_i ),
    .wr_ready_o ( wr_ready_o ),
    .b_valid_o  ( b_valid_o  ),
    .b_ready_i  ( b_ready_i  ),
    .rd_addr_i  ( rd_addr_i  ),
    .rd_valid_i ( rd_valid_i ),
    .rd_ready_o ( rd_ready_o ),
    .r_valid_o  ( r_valid_o  ),
    .r_ready_i  ( r_ready_i  ),
    .r_data_o   ( r_data_o   ),
    .reg_wr_o   ( reg_wr     ),
    .cnt_i      ( cnt        ),
    .ctrl_i     ( ctrl       ),
    .status_i   ( status     ),
    .mask_i     ( mask       )
  );

  event_edge_rx i_dma_evt_rx (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .pulse_o ( dma_evt            )
  );

  perf_counter_bank #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) i_perf_counter_bank (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .reg_wr_i  ( reg_wr    ),
    .evt_i     ( evt       ),
    .cnt_o     ( cnt       ),
    .ctrl_o    ( ctrl      ),
    .status_o  ( status    ),
    .mask_o    ( mask      ),
    .irq_o     ( irq_o     )
  );

endmodule

//--- verif/host_event_monitor_assertions.sv
// Concurrent checks on the register port handshake and the interrupt

`timescale 1ns/1ps

module host_event_monitor_assertions (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic                               wr_ready_i,
  input logic                               b_valid_i,
  input logic                               b_ready_i,
  input logic                               r_valid_i,
  input logic                               r_ready_i,
  input logic [host_event_pkg::CFG_DW-1:0]  r_data_i,
  input logic [host_event_pkg::NUM_EVT-1:0] status_i,
  input logic [host_event_pkg::NUM_EVT-1:0] mask_i,
  input logic                               irq_i
);

  b_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i)
    else $error("write response dropped before it was accepted");

  r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i))
    else $error("read response dropped or changed before it was accepted");

  wr_ready_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr_ready_i && b_valid_i))
    else $error("write ready high while a write response is pending");

  // Interrupt is registered, so the cause lies one cycle back
  irq_rise_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_i) |-> $past(|(status_i & mask_i)))
    else $error("interrupt rose without a masked status bit");

endmodule

bind host_event_monitor host_event_monitor_assertions i_assertions (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .wr_ready_i ( wr_ready_o ),
  .b_valid_i  ( b_valid_o  ),
  .b_ready_i  ( b_ready_i  ),
  .r_valid_i  ( r_valid_o  ),
  .r_ready_i  ( r_ready_i  ),
  .r_data_i   ( r_data_o   ),
  .status_i   ( status     ),
  .mask_i     ( mask       ),
  .irq_i      ( irq_o      )
);

//--- verif/tb_host_event_monitor.sv
// Testbench for the event monitor
// Register access, random counting, overflow, DMA toggle and back-pressure tests

`timescale 1ns/1ps

module tb_host_event_monitor;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_CYCLES  = 200;
  localparam int DMA_TOGGLES  = 6;
  // Cycle budget per test, a register access costs about three cycles
  localparam int TEST_CYCLES  = RESET_CYCLES + 60 + 80 + (RAND_CYCLES + 60) + 2 * 60
                                + DMA_TOGGLES * 8 + 60;

  logic                          clk;
  logic                          rst_n;
  host_event_pkg::cfg_wr_t       cfg_wr;
  logic                          wr_valid;
  logic                          wr_ready_o;
  logic                          b_valid_o;
  logic                          b_ready;
  logic [7:0]                    rd_addr;
  logic                          rd_valid;
  logic                          rd_ready_o;
  logic                          r_valid_o;
  logic                          r_ready;
  logic [31:0]                   r_data_o;
  host_event_pkg::llc_events_t   llc_evt;
  logic                          dma_valid;
  logic                          dma_ack;
  logic                          irq_o;

  logic [31:0] lfsr = 32'h3892;
  int          err_cnt = 0;
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  host_event_monitor #(
    .CNT_WIDTH ( 8 )
  ) DUT (
    .clk_i              ( clk        ),
    .rst_n_i            ( rst_n      ),
    .cfg_wr_i           ( cfg_wr     ),
    .wr_valid_i         ( wr_valid   ),
    .wr_ready_o         ( wr_ready_o ),
    .b_valid_o          ( b_valid_o  ),
    .b_ready_i          ( b_ready    ),
    .rd_addr_i          ( rd_addr    ),
    .rd_valid_i         ( rd_valid   ),
    .rd_ready_o         ( rd_ready_o ),
    .r_valid_o          ( r_valid_o  ),
    .r_ready_i          ( r_ready    ),
    .r_data_o           ( r_data_o   ),
    .llc_evt_i          ( llc_evt    ),
    .dma_pe_evt_valid_i ( dma_valid  ),
    .dma_pe_evt_ack_o   ( dma_ack    ),
    .irq_o              ( irq_o      )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v[b] = lfsr[0];
    end
  endtask

  // Expected 8-bit count after a number of pulses, MSB flags a wrap
  function automatic logic [8:0] ref_count(input int start, input int pulses);
    int total;
    total = start + pulses;
    ref_count = {total > 255, 8'(total % 256)};
  endfunction

  function automatic logic [7:0] cnt_offs(input int idx);
    cnt_offs = host_event_pkg::CNT_BASE_OFFS + 8'(4 * idx);
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  always @(negedge clk) begin
    while (act_q.size() > 0) begin
      compare(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  task automatic drive_events(input logic [3:0] v);
    llc_evt.read_hit   = v[0];
    llc_evt.read_miss  = v[1];
    llc_evt.write_hit  = v[2];
    llc_evt.write_miss = v[3];
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    cfg_wr   = '{addr: addr, data: data};
    wr_valid = 1'b1;
    while (!wr_ready_o) @(negedge clk);
    @(negedge clk);
    wr_valid = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    rd_addr  = addr;
    rd_valid = 1'b1;
    while (!rd_ready_o) @(negedge clk);
    @(negedge clk);
    rd_valid = 1'b0;
    while (!r_valid_o) @(negedge clk);
    data = r_data_o;
  endtask

  task automatic check_read(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    read_reg(addr, data);
    expect_val(name, exp, data);
  endtask

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin : main
    logic [31:0] v;
    logic [31:0] data;
    logic [4:0]  en;
    logic [4:0]  m;
    logic [4:0]  exp_st;
    logic [8:0]  r;
    int          n [4];
    int          idx;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cfg_wr    = '0;
    wr_valid  = 1'b0;
    b_ready   = 1'b1;
    rd_addr   = '0;
    rd_valid  = 1'b0;
    r_ready   = 1'b1;
    llc_evt   = '0;
    dma_valid = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Reset state: irq, b_valid, r_valid, ack low, both readys high
    expect_val("reset_flags", 32'h3,
               32'({irq_o, b_valid_o, r_valid_o, dma_ack, wr_ready_o, rd_ready_o}));
    check_read("reset_ctrl", host_event_pkg::CTRL_OFFS, 32'h0);
    check_read("reset_status", host_event_pkg::STATUS_OFFS, 32'h0);
    check_read("reset_mask", host_event_pkg::MASK_OFFS, 32'h0);
    for (int i = 0; i < 5; i++) begin
      check_read($sformatf("reset_cnt%0d", i), cnt_offs(i), 32'h0);
    end
    check_read("unmapped_0c", 8'h0c, 32'hdeadf000);
    check_read("unmapped_24", 8'h24, 32'hdeadf000);
    check_read("unmapped_fc", 8'hfc, 32'hdeadf000);

    // Read back, only the low five bits of the control words exist
    write_reg(host_event_pkg::CTRL_OFFS, 32'hffff_ffea);
    check_read("wr_ctrl", host_event_pkg::CTRL_OFFS, 32'h0a);
    write_reg(host_event_pkg::MASK_OFFS, 32'hffff_ff35);
    check_read("wr_mask", host_event_pkg::MASK_OFFS, 32'h15);
    write_reg(host_event_pkg::STATUS_OFFS, 32'hffff_ffff);
    check_read("wr_status", host_event_pkg::STATUS_OFFS, 32'h0);
    for (int i = 0; i < 5; i++) begin
      v = 32'h1234_5600 + 32'(17 * i + 33);
      write_reg(cnt_offs(i), v);
      check_read($sformatf("wr_cnt%0d", i), cnt_offs(i), 32'(v[7:0]));
      write_reg(cnt_offs(i), 32'h0);
    end
    write_reg(host_event_pkg::CTRL_OFFS, 32'h0);
    write_reg(host_event_pkg::MASK_OFFS, 32'h0);

    // Random cache events under a random enable mask
    rand_bits(5, v);
    en = v[4:0];
    write_reg(host_event_pkg::CTRL_OFFS, 32'(en));
    for (int i = 0; i < 4; i++) n[i] = 0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(negedge clk);
      rand_bits(4, v);
      drive_events(v[3:0]);
      for (int i = 0; i < 4; i++) begin
        if (v[i] && en[i]) n[i]++;
      end
    end
    @(negedge clk);
    drive_events(4'h0);
    write_reg(host_event_pkg::CTRL_OFFS, 32'h0);
    exp_st = '0;
    for (int i = 0; i < 4; i++) begin
      r = ref_count(0, n[i]);
      exp_st = exp_st | (5'(r[8]) << i);
      check_read($sformatf("rand_cnt%0d", i), cnt_offs(i), 32'(r[7:0]));
    end
    check_read("rand_cnt4", cnt_offs(4), 32'h0);
    check_read("rand_status", host_event_pkg::STATUS_OFFS, 32'(exp_st));

    // Overflow from 255, once with the mask bit set and once without
    for (int round = 0; round < 2; round++) begin
      rand_bits(2, v);
      idx = int'(v[1:0]);
      rand_bits(5, v);
      m = (round == 0) ? (v[4:0] | (5'b1 << idx)) : (v[4:0] & ~(5'b1 << idx));
      r = ref_count(255, 1);
      exp_st = 5'(r[8]) << idx;
      write_reg(cnt_offs(idx), 32'hff);
      write_reg(host_event_pkg::CTRL_OFFS, 32'(5'b1 << idx));
      write_reg(host_event_pkg::MASK_OFFS, 32'(m));
      @(negedge clk);
      drive_events(4'b1 << idx);
      @(negedge clk);
      drive_events(4'h0);
      @(negedge clk);
      expect_val("ovf_irq", 32'(|(exp_st & m)), 32'(irq_o));
      check_read("ovf_cnt", cnt_offs(idx), 32'(r[7:0]));
      check_read("ovf_status", host_event_pkg::STATUS_OFFS, 32'(exp_st));
      write_reg(host_event_pkg::STATUS_OFFS, 32'h1f);
      expect_val("clr_irq_hold", 32'(|(exp_st & m)), 32'(irq_o));
      @(negedge clk);
      expect_val("clr_irq", 32'h0, 32'(irq_o));
      check_read("clr_status", host_event_pkg::STATUS_OFFS, 32'h0);
    end
    write_reg(host_event_pkg::MASK_OFFS, 32'h0);

    // DMA toggles, ack after two edges, count after three
    write_reg(cnt_offs(4), 32'h0);
    write_reg(host_event_pkg::CTRL_OFFS, 32'h10);
    for (int k = 0; k < DMA_TOGGLES; k++) begin
      @(negedge clk);
      dma_valid = ~dma_valid;
      @(negedge clk);
      expect_val("ack_one_edge", 32'(!dma_valid), 32'(dma_ack));
      @(negedge clk);
      expect_val("ack_two_edges", 32'(dma_valid), 32'(dma_ack));
      @(negedge clk);
      r = ref_count(0, k + 1);
      check_read("dma_cnt", cnt_offs(4), 32'(r[7:0]));
    end

    // Write response held under back-pressure
    write_reg(cnt_offs(0), 32'h40);
    write_reg(host_event_pkg::CTRL_OFFS, 32'h01);
    // Let the previous write response drain
    @(negedge clk);
    b_ready = 1'b0;
    @(negedge clk);
    cfg_wr   = '{addr: host_event_pkg::MASK_OFFS, data: 32'h3};
    wr_valid = 1'b1;
    @(negedge clk);
    wr_valid = 1'b0;
    repeat (5) begin
      @(negedge clk);
      expect_val("b_hold", 32'h2, 32'({b_valid_o, wr_ready_o}));
    end
    b_ready = 1'b1;
    @(negedge clk);
    expect_val("b_release", 32'h1, 32'({b_valid_o, wr_ready_o}));
    check_read("bp_mask", host_event_pkg::MASK_OFFS, 32'h3);

    // Read response held while counter 0 keeps counting
    @(negedge clk);
    r_ready = 1'b0;
    read_reg(cnt_offs(0), data);
    expect_val("r_accept", 32'h40, data);
    repeat (5) begin
      drive_events(4'h1);
      @(negedge clk);
      expect_val("r_hold", 32'h2, 32'({r_valid_o, rd_ready_o}));
      expect_val("r_data_hold", 32'h40, r_data_o);
    end
    drive_events(4'h0);
    r_ready = 1'b1;
    @(negedge clk);
    expect_val("r_release", 32'h1, 32'({r_valid_o, rd_ready_o}));
    r = ref_count(64, 5);
    check_read("bp_cnt", cnt_offs(0), 32'(r[7:0]));

    while (act_q.size() != 0) @(negedge clk);
    if (err_cnt == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "%0d mismatches", err_cnt);
    end
  end

endmodule

//--- all.f
source/host_event_pkg.sv
source/cfg_reg_port.sv
source/event_edge_rx.sv
source/perf_counter_bank.sv
source/host_event_monitor.sv
verif/host_event_monitor_assertions.sv
verif/tb_host_event_monitor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the event monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f \
  --top-module tb_host_event_monitor -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
